//--- rtl/mhu_pkg.sv
package mhu_pkg;

  // Cache geometry.
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int ID_W        = 4;
  localparam int WAYS        = 4;
  localparam int SETS        = 16;
  localparam int BLOCK_WORDS = 4;

  // Address layout is {tag, index, word, byte}.
  localparam int WAY_W    = $clog2(WAYS);
  localparam int INDEX_W  = $clog2(SETS);
  localparam int WORD_W   = $clog2(BLOCK_WORDS);
  localparam int BYTE_W   = $clog2(DATA_W / 8);
  localparam int MASK_W   = DATA_W / 8;
  localparam int OFFSET_W = WORD_W + BYTE_W;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // Bit 0 of the pseudo-LRU tree is the root, bit 1 the left pair and bit 2 the right pair.
  localparam int LRU_W     = WAYS - 1;
  localparam int LRU_ROOT  = 0;
  localparam int LRU_LEFT  = 1;
  localparam int LRU_RIGHT = 2;

  // Miss queue sizing.
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic              write_not_read;
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] mask;
  } miss_entry_t;

  typedef struct packed {
    logic [WAY_W-1:0]   way;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   refill_tag;
    logic               evict;
    logic [TAG_W-1:0]   evict_tag;
  } dma_cmd_t;

  typedef struct packed {
    logic               write_not_read;
    logic [ID_W-1:0]    id;
    logic [WAY_W-1:0]   way;
    logic [INDEX_W-1:0] index;
    logic [WORD_W-1:0]  word;
    logic [DATA_W-1:0]  data;
    logic [MASK_W-1:0]  mask;
  } data_pkt_t;

  typedef struct packed {
    logic [WAYS-1:0]             valid;
    logic [WAYS-1:0]             dirty;
    logic [WAYS-1:0][TAG_W-1:0]  tag;
    logic [LRU_W-1:0]            lru;
  } line_state_t;

  typedef struct packed {
    logic [INDEX_W-1:0] index;
    logic [WAY_W-1:0]   way;
    logic [TAG_W-1:0]   tag;
    logic               dirty;
    logic [LRU_W-1:0]   lru;
  } line_update_t;

endpackage

//--- rtl/miss_queue.sv
module miss_queue
  import mhu_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        push_v_i,
  input  miss_entry_t push_i,
  output logic        ready_o,
  output logic        head_v_o,
  output miss_entry_t head_o,
  input  logic        pop_i
);

  miss_entry_t mem_r [QUEUE_DEPTH];

  logic [QPTR_W-1:0] wr_ptr_r;
  logic [QPTR_W-1:0] rd_ptr_r;
  logic [QCNT_W-1:0] count_r;
  logic [QCNT_W-1:0] count_n;
  logic              ready_r;
  logic              push;
  logic              pop;

  assign push = push_v_i & ready_r;
  assign pop  = pop_i & head_v_o;

  // Count after this cycle's push and pop.
  assign count_n = count_r + QCNT_W'(push) - QCNT_W'(pop);

  assign ready_o  = ready_r;
  assign head_v_o = (count_r != '0);
  assign head_o   = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      ready_r  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      count_r <= count_n;
      // Ready for the next cycle follows the updated count.
      ready_r <= (count_n != QCNT_W'(QUEUE_DEPTH));
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= push_i;
    end
  end

endmodule

//--- rtl/line_state_store.sv
module line_state_store
  import mhu_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [INDEX_W-1:0] index_i,
  output line_state_t        state_o,
  input  logic               update_v_i,
  input  line_update_t       update_i
);

  logic [SETS-1:0][WAYS-1:0]            valid_r;
  logic [SETS-1:0][WAYS-1:0]            dirty_r;
  logic [SETS-1:0][WAYS-1:0][TAG_W-1:0] tag_r;
  logic [SETS-1:0][LRU_W-1:0]           lru_r;

  // Combinational read of the selected set.
  always_comb begin
    state_o.valid = valid_r[index_i];
    state_o.dirty = dirty_r[index_i];
    state_o.tag   = tag_r[index_i];
    state_o.lru   = lru_r[index_i];
  end

  // Status bits.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
      dirty_r <= '0;
      lru_r   <= '0;
    end else if (update_v_i) begin
      valid_r[update_i.index][update_i.way] <= 1'b1;
      dirty_r[update_i.index][update_i.way] <= update_i.dirty;
      lru_r[update_i.index]                 <= update_i.lru;
    end
  end

  // Tag of the filled way.
  always_ff @(posedge clk_i) begin
    if (update_v_i) begin
      tag_r[update_i.index][update_i.way] <= update_i.tag;
    end
  end

endmodule

//--- rtl/victim_select.sv
module victim_select
  import mhu_pkg::*;
(
  input  line_state_t      state_i,
  output logic [WAY_W-1:0] way_o,
  output logic             evict_o
);

  logic             invalid_found;
  logic [WAY_W-1:0] invalid_way;
  logic [WAY_W-1:0] lru_way;

  // Lowest-numbered invalid way.
  always_comb begin
    invalid_found = 1'b0;
    invalid_way   = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!state_i.valid[w]) begin
        invalid_found = 1'b1;
        invalid_way   = WAY_W'(w);
      end
    end
  end

  // The root bit picks the pair and the leaf bit picks the way in it.
  always_comb begin
    if (state_i.lru[LRU_ROOT]) begin
      lru_way = {1'b1, state_i.lru[LRU_RIGHT]};
    end else begin
      lru_way = {1'b0, state_i.lru[LRU_LEFT]};
    end
  end

  assign way_o = invalid_found ? invalid_way : lru_way;

  // Only a valid dirty line needs a writeback.
  assign evict_o = state_i.valid[way_o] & state_i.dirty[way_o];

endmodule

//--- rtl/miss_sequencer.sv
module miss_sequencer
  import mhu_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,

  // Miss queue head.
  input  logic               head_v_i,
  input  miss_entry_t        head_i,
  output logic               pop_o,

  // Line state.
  output logic [INDEX_W-1:0] index_o,
  input  line_state_t        state_i,
  input  logic [WAY_W-1:0]   victim_way_i,
  input  logic               victim_evict_i,
  output logic               update_v_o,
  output line_update_t       update_o,

  // DMA.
  output logic               dma_cmd_v_o,
  output dma_cmd_t           dma_cmd_o,
  input  logic               dma_done_i,

  // Data memory.
  output logic               data_v_o,
  output data_pkt_t          data_o,
  input  logic               data_yumi_i,

  output logic               busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_DMA,
    DRAIN,
    COMMIT
  } state_e;

  state_e   state_r;
  state_e   state_n;
  dma_cmd_t cmd_r;
  logic     set_dirty_r;

  logic [TAG_W-1:0]   head_tag;
  logic [INDEX_W-1:0] head_index;
  logic [WORD_W-1:0]  head_word;
  logic               head_match;
  logic [LRU_W-1:0]   new_lru;

  assign head_tag   = head_i.addr[OFFSET_W + INDEX_W +: TAG_W];
  assign head_index = head_i.addr[OFFSET_W +: INDEX_W];
  assign head_word  = head_i.addr[BYTE_W +: WORD_W];

  // Head belongs to the block currently being refilled.
  assign head_match = head_v_i & (head_tag == cmd_r.refill_tag) & (head_index == cmd_r.index);

  assign index_o = (state_r == IDLE) ? head_index : cmd_r.index;
  assign busy_o  = (state_r != IDLE);

  // Command is held stable from issue until done.
  assign dma_cmd_v_o = (state_r == WAIT_DMA);
  assign dma_cmd_o   = cmd_r;

  assign data_v_o              = (state_r == DRAIN) & head_match;
  assign data_o.write_not_read = head_i.write_not_read;
  assign data_o.id             = head_i.id;
  assign data_o.way            = cmd_r.way;
  assign data_o.index          = cmd_r.index;
  assign data_o.word           = head_word;
  assign data_o.data           = head_i.data;
  assign data_o.mask           = head_i.mask;

  assign pop_o = data_v_o & data_yumi_i;

  // New LRU bits point away from the filled way.
  always_comb begin
    new_lru           = state_i.lru;
    new_lru[LRU_ROOT] = ~cmd_r.way[1];
    if (!cmd_r.way[1]) begin
      new_lru[LRU_LEFT] = ~cmd_r.way[0];
    end else begin
      new_lru[LRU_RIGHT] = ~cmd_r.way[0];
    end
  end

  assign update_v_o     = (state_r == COMMIT);
  assign update_o.index = cmd_r.index;
  assign update_o.way   = cmd_r.way;
  assign update_o.tag   = cmd_r.refill_tag;
  assign update_o.dirty = set_dirty_r;
  assign update_o.lru   = new_lru;

  always_comb begin
    state_n = state_r;
    case (state_r)
      IDLE: begin
        if (head_v_i) begin
          state_n = WAIT_DMA;
        end
      end
      WAIT_DMA: begin
        if (dma_done_i) begin
          state_n = DRAIN;
        end
      end
      // Leave once the head is empty or a different block.
      DRAIN: begin
        if (!head_match) begin
          state_n = COMMIT;
        end
      end
      COMMIT: begin
        state_n = IDLE;
      end
      default: begin
        state_n = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= IDLE;
      set_dirty_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (state_r == IDLE) begin
        set_dirty_r <= 1'b0;
      end else if (pop_o && head_i.write_not_read) begin
        set_dirty_r <= 1'b1;
      end
    end
  end

  // Capture the primary miss's block and its victim.
  always_ff @(posedge clk_i) begin
    if (state_r == IDLE && head_v_i) begin
      cmd_r.way        <= victim_way_i;
      cmd_r.index      <= head_index;
      cmd_r.refill_tag <= head_tag;
      cmd_r.evict      <= victim_evict_i;
      cmd_r.evict_tag  <= state_i.tag[victim_way_i];
    end
  end

endmodule

//--- rtl/cache_mhu_top.sv
module cache_mhu_top
  import mhu_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,

  input  logic        miss_v_i,
  input  miss_entry_t miss_i,
  output logic        miss_ready_o,

  output logic        dma_cmd_v_o,
  output dma_cmd_t    dma_cmd_o,
  input  logic        dma_done_i,

  output logic        data_v_o,
  output data_pkt_t   data_o,
  input  logic        data_yumi_i,

  output logic        idle_o
);

  logic               head_v;
  miss_entry_t        head;
  logic               pop;
  logic [INDEX_W-1:0] index;
  line_state_t        line_state;
  logic [WAY_W-1:0]   victim_way;
  logic               victim_evict;
  logic               update_v;
  line_update_t       update;
  logic               busy;

  miss_queue i_miss_queue (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_v_i(miss_v_i),
    .push_i  (miss_i),
    .ready_o (miss_ready_o),
    .head_v_o(head_v),
    .head_o  (head),
    .pop_i   (pop)
  );

  line_state_store i_line_state_store (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .index_i   (index),
    .state_o   (line_state),
    .update_v_i(update_v),
    .update_i  (update)
  );

  victim_select i_victim_select (
    .state_i(line_state),
    .way_o  (victim_way),
    .evict_o(victim_evict)
  );

  miss_sequencer i_miss_sequencer (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .head_v_i      (head_v),
    .head_i        (head),
    .pop_o         (pop),
    .index_o       (index),
    .state_i       (line_state),
    .victim_way_i  (victim_way),
    .victim_evict_i(victim_evict),
    .update_v_o    (update_v),
    .update_o      (update),
    .dma_cmd_v_o   (dma_cmd_v_o),
    .dma_cmd_o     (dma_cmd_o),
    .dma_done_i    (dma_done_i),
    .data_v_o      (data_v_o),
    .data_o        (data_o),
    .data_yumi_i   (data_yumi_i),
    .busy_o        (busy)
  );

  // Idle only with nothing queued and nothing in flight.
  assign idle_o = ~head_v & ~busy;

endmodule

//--- sim/mhu_ref_model.svh
// Expected line state, queue contents and the command being served.
typedef enum int {M_IDLE, M_WAIT, M_DRAIN, M_COMMIT} model_phase_e;

logic [WAYS-1:0]  exp_valid [SETS];
logic [WAYS-1:0]  exp_dirty [SETS];
logic [TAG_W-1:0] exp_tag   [SETS][WAYS];
logic [LRU_W-1:0] exp_lru   [SETS];
miss_entry_t      model_q   [$];
dma_cmd_t         cur_cmd;
model_phase_e     phase;
logic             drain_dirty;
int               primaries;
int               dirty_evicts;

task automatic init_model();
  exp_valid    = '{default: '0};
  exp_dirty    = '{default: '0};
  exp_tag      = '{default: '0};
  exp_lru      = '{default: '0};
  phase        = M_IDLE;
  drain_dirty  = 1'b0;
  primaries    = 0;
  dirty_evicts = 0;
endtask

// Invalid way first, otherwise walk the pseudo-LRU tree.
function automatic dma_cmd_t expected_cmd(input miss_entry_t e);
  dma_cmd_t           c;
  logic [INDEX_W-1:0] idx;
  logic [WAYS-1:0]    v;
  logic [LRU_W-1:0]   l;
  logic [WAY_W-1:0]   way;
  idx = e.addr[OFFSET_W +: INDEX_W];
  v   = exp_valid[idx];
  l   = exp_lru[idx];
  if (!v[0]) way = 2'd0;
  else if (!v[1]) way = 2'd1;
  else if (!v[2]) way = 2'd2;
  else if (!v[3]) way = 2'd3;
  else if (l[0]) way = l[2] ? 2'd3 : 2'd2;
  else way = l[1] ? 2'd1 : 2'd0;
  c.way        = way;
  c.index      = idx;
  c.refill_tag = e.addr[ADDR_W-1 -: TAG_W];
  c.evict      = v[way] & exp_dirty[idx][way];
  // An empty way has no meaningful tag.
  c.evict_tag  = v[way] ? exp_tag[idx][way] : '0;
  return c;
endfunction

function automatic logic [LRU_W-1:0] lru_after_fill(input logic [LRU_W-1:0] old,
                                                    input logic [WAY_W-1:0] way);
  logic [LRU_W-1:0] lru;
  lru = old;
  lru[LRU_ROOT] = (way == 2'd0) || (way == 2'd1);
  if (way < 2'd2) lru[LRU_LEFT] = (way != 2'd1);
  else lru[LRU_RIGHT] = (way != 2'd3);
  return lru;
endfunction

function automatic logic same_block(input miss_entry_t e);
  return e.addr[ADDR_W-1:OFFSET_W] == {cur_cmd.refill_tag, cur_cmd.index};
endfunction

function automatic data_pkt_t expected_pkt(input miss_entry_t e);
  data_pkt_t p;
  p.write_not_read = e.write_not_read;
  p.id             = e.id;
  p.way            = cur_cmd.way;
  p.index          = cur_cmd.index;
  p.word           = e.addr[BYTE_W +: WORD_W];
  p.data           = e.data;
  p.mask           = e.mask;
  return p;
endfunction

task automatic commit_line();
  exp_valid[cur_cmd.index][cur_cmd.way] = 1'b1;
  exp_dirty[cur_cmd.index][cur_cmd.way] = drain_dirty;
  exp_tag[cur_cmd.index][cur_cmd.way]   = cur_cmd.refill_tag;
  exp_lru[cur_cmd.index] = lru_after_fill(exp_lru[cur_cmd.index], cur_cmd.way);
endtask

//--- sim/cache_mhu_tb.sv
module cache_mhu_tb
  import mhu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_MISSES = 300;
  localparam int CLK_PERIOD = 10;

  logic        clk_i;
  logic        reset_i;
  logic        miss_v_i;
  miss_entry_t miss_i;
  logic        miss_ready_o;
  logic        dma_cmd_v_o;
  dma_cmd_t    dma_cmd_o;
  logic        dma_done_i;
  logic        data_v_o;
  data_pkt_t   data_o;
  logic        data_yumi_i;
  logic        idle_o;

  logic [31:0]        seed;
  int                 gen_count;
  int                 errors;
  int                 dma_delay;
  int                 cmd_count;
  logic               cmd_v_prev;
  logic               miss_taken;
  logic               have_prev;
  logic [TAG_W-1:0]   prev_tag;
  logic [INDEX_W-1:0] prev_index;

  `include "mhu_ref_model.svh"

  cache_mhu_top i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .miss_v_i    (miss_v_i),
    .miss_i      (miss_i),
    .miss_ready_o(miss_ready_o),
    .dma_cmd_v_o (dma_cmd_v_o),
    .dma_cmd_o   (dma_cmd_o),
    .dma_done_i  (dma_done_i),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .data_yumi_i (data_yumi_i),
    .idle_o      (idle_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Error: %s expected %h got %h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift32(seed);
    return seed;
  endfunction

  // About half the misses reuse the previous block.
  task automatic build_miss(output miss_entry_t e);
    logic [31:0]        r;
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    r = next_rand();
    if (have_prev && r[0]) begin
      tag   = prev_tag;
      index = prev_index;
    end else begin
      // Four sets and six tags, so sets overflow and lines get evicted.
      index = {r[2:1], 2'b01};
      tag   = TAG_W'(32'h5c0a0 + (r[15:8] % 8'd6) * 32'h111);
    end
    e.id             = ID_W'(gen_count);
    e.addr           = {tag, index, r[17:16], 2'b00};
    e.write_not_read = r[20];
    e.data           = next_rand();
    e.mask           = r[27:24];
    prev_tag         = tag;
    prev_index       = index;
    have_prev        = 1'b1;
    gen_count++;
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    if (miss_taken) begin
      miss_v_i   = 1'b0;
      miss_taken = 1'b0;
    end
    r = next_rand();
    if (!miss_v_i && gen_count < NUM_MISSES && r[2:0] != 3'd0) begin
      build_miss(miss_i);
      miss_v_i = 1'b1;
    end
    // One-cycle done pulse at the end of the DMA delay.
    dma_done_i = (phase == M_WAIT && dma_delay == 1);
    if (phase == M_WAIT) dma_delay--;
    data_yumi_i = r[5:3] > 3'd4;
  endtask

  // Runs mid-cycle; handshakes seen here complete at the next rising edge.
  task automatic observe();
    logic     exp_v;
    dma_cmd_t got_cmd;
    exp_v = 1'b0;
    if (phase == M_DRAIN && model_q.size() != 0) exp_v = same_block(model_q[0]);
    check_value("miss_ready_o", 64'(model_q.size() < QUEUE_DEPTH), 64'(miss_ready_o));
    check_value("idle_o", 64'(phase == M_IDLE && model_q.size() == 0), 64'(idle_o));
    check_value("dma_cmd_v_o", 64'(phase == M_WAIT), 64'(dma_cmd_v_o));
    check_value("data_v_o", 64'(exp_v), 64'(data_v_o));
    case (phase)
      M_IDLE: begin
        if (model_q.size() != 0) begin
          cur_cmd = expected_cmd(model_q[0]);
          primaries++;
          if (cur_cmd.evict) dirty_evicts++;
          drain_dirty = 1'b0;
          dma_delay   = 1 + int'(next_rand() % 32'd8);
          phase       = M_WAIT;
        end
      end
      M_WAIT: begin
        got_cmd = dma_cmd_o;
        if (!exp_valid[cur_cmd.index][cur_cmd.way]) got_cmd.evict_tag = '0;
        check_value("dma_cmd_o", 64'(cur_cmd), 64'(got_cmd));
        if (dma_done_i) phase = M_DRAIN;
      end
      M_DRAIN: begin
        if (exp_v) begin
          check_value("data_o", 64'(expected_pkt(model_q[0])), 64'(data_o));
          if (data_yumi_i) begin
            drain_dirty = drain_dirty | model_q[0].write_not_read;
            void'(model_q.pop_front());
          end
        end else begin
          commit_line();
          phase = M_COMMIT;
        end
      end
      default: phase = M_IDLE;
    endcase
    if (miss_v_i && miss_ready_o) begin
      model_q.push_back(miss_i);
      miss_taken = 1'b1;
    end
    if (dma_cmd_v_o && !cmd_v_prev) cmd_count++;
    cmd_v_prev = dma_cmd_v_o;
  endtask

  initial begin
    seed        = 32'h18d1;
    gen_count   = 0;
    errors      = 0;
    dma_delay   = 0;
    cmd_count   = 0;
    cmd_v_prev  = 1'b0;
    miss_taken  = 1'b0;
    have_prev   = 1'b0;
    prev_tag    = '0;
    prev_index  = '0;
    reset_i     = 1'b1;
    miss_v_i    = 1'b0;
    miss_i      = '0;
    dma_done_i  = 1'b0;
    data_yumi_i = 1'b0;
    init_model();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_value("miss_ready_o", 64'(1'b0), 64'(miss_ready_o));
    check_value("dma_cmd_v_o", 64'(1'b0), 64'(dma_cmd_v_o));
    check_value("data_v_o", 64'(1'b0), 64'(data_v_o));
    @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(posedge clk_i);
    #1;
    while (!(gen_count == NUM_MISSES && !miss_v_i && model_q.size() == 0 &&
             phase == M_IDLE)) begin
      drive_inputs();
      @(negedge clk_i);
      observe();
      @(posedge clk_i);
      #1;
    end
    @(negedge clk_i);
    check_value("idle_o", 64'(1'b1), 64'(idle_o));
    check_value("dma_cmd_count", 64'(primaries), 64'(cmd_count));
    if (dirty_evicts == 0) begin
      errors++;
      $display("No dirty line was ever evicted during the run");
    end
    if (errors == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "Checks failed");
    end
  end

  // Generous bound of sixty cycles per miss.
  initial begin
    #(NUM_MISSES * 60 * CLK_PERIOD);
    $display("Watchdog expired before all misses were handled");
    $display("Result: FAILED");
    $fatal(1, "Timeout");
  end

endmodule

//--- cache_mhu.f
+incdir+sim
rtl/mhu_pkg.sv
rtl/miss_queue.sv
rtl/line_state_store.sv
rtl/victim_select.sv
rtl/miss_sequencer.sv
rtl/cache_mhu_top.sv
sim/cache_mhu_tb.sv

//--- Makefile
TOP = cache_mhu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f cache_mhu.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
